// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := dcache_tb
FILELIST := dcache.f
BUILD    := obj_dir
LOG      := sim.log
FAIL_MSG := Simulation finished: FAIL

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== common/dcache_pkg.sv ====
package dcache_pkg;

  // --------------------------------------------------------------------------
  // Cache geometry
  // --------------------------------------------------------------------------
  localparam int dcache_ways        = 2;
  localparam int dcache_banks       = 4;
  localparam int dcache_bank_bytes  = 4;
  localparam int dcache_index_width = 6;
  localparam int dcache_tag_width   = 22;
  localparam int dcache_sets        = 2 ** dcache_index_width;

  // Derived widths
  localparam int dcache_addr_width      = 32;
  localparam int dcache_word_width      = dcache_bank_bytes * 8;
  localparam int dcache_line_width      = dcache_banks * dcache_word_width;
  localparam int dcache_bank_sel_width  = $clog2(dcache_banks);
  localparam int dcache_byte_sel_width  = $clog2(dcache_bank_bytes);

  // --------------------------------------------------------------------------
  // Width types
  // --------------------------------------------------------------------------
  typedef logic [dcache_tag_width-1:0]   dcache_tag_t;
  typedef logic [dcache_index_width-1:0] dcache_index_t;
  typedef logic [dcache_line_width-1:0]  dcache_line_t;
  typedef logic                          dcache_way_t;

  // Address seen two ways
  // raw word from the core, or split into lookup fields
  //   | tag 31:10 | index 9:4 | bank 3:2 | byte 1:0 |
  typedef union packed {
    logic [dcache_addr_width-1:0] raw;
    struct packed {
      dcache_tag_t                      tag;
      dcache_index_t                    index;
      logic [dcache_bank_sel_width-1:0] bank;
      logic [dcache_byte_sel_width-1:0] byte_off;
    } f;
  } dcache_addr_u;

endpackage : dcache_pkg

// ==== dcache.f ====
common/dcache_pkg.sv
rtl/single_port_ram.sv
dcache_data/dcache_data_banks.sv
dcache_tag/dcache_tag_array.sv
rtl/dcache_hit_select.sv
rtl/dcache.sv
verif/dcache_tb.sv

// ==== dcache_data/dcache_data_banks.sv ====
module dcache_data_banks (
  input  logic                                clk,
  input  logic                                reset_i,
  input  logic [1:0]                          rd_valid_i,
  input  dcache_pkg::dcache_addr_u [1:0]      rd_addr_i,
  input  logic                                wr_valid_i,
  input  dcache_pkg::dcache_addr_u            wr_addr_i,
  input  dcache_pkg::dcache_way_t             wr_way_i,
  input  dcache_pkg::dcache_line_t            wr_line_i,
  output logic [1:0]                          rd_ready_o,
  output logic                                wr_ready_o,
  output logic [1:0]                          rd_accept_o,
  output logic [1:0][dcache_pkg::dcache_ways-1:0][dcache_pkg::dcache_word_width-1:0] bank_data_o
);

  import dcache_pkg::*;

  // --------------------------------------------------------------------------
  // Arbitration
  // --------------------------------------------------------------------------
  logic          same_bank;
  logic          conflict;
  logic          wr_accept;

  // Per bank address, enable and write data
  dcache_index_t [dcache_banks-1:0]                        bank_index;
  logic [dcache_banks-1:0]                                 bank_en;
  logic [dcache_ways-1:0]                                  way_we;
  logic [dcache_ways-1:0][dcache_banks-1:0][dcache_word_width-1:0] ram_q;

  // Bank used by each port, one cycle late
  logic [1:0][dcache_bank_sel_width-1:0] bank_q;

  assign same_bank = rd_addr_i[0].f.bank == rd_addr_i[1].f.bank;

  // Same bank, same index: one RAM read serves both ports
  assign conflict = rd_valid_i[0] && rd_valid_i[1] && same_bank
                    && (rd_addr_i[0].f.index != rd_addr_i[1].f.index);

  // Port 0 always wins
  assign rd_ready_o[0] = 1'b1;
  assign rd_ready_o[1] = !conflict;

  // Line write needs every bank, loads first
  assign wr_ready_o = !(|rd_valid_i);

  assign rd_accept_o = rd_valid_i & rd_ready_o;
  assign wr_accept   = wr_valid_i && wr_ready_o;

  // Only the chosen way takes the line
  for (genvar w = 0; w < dcache_ways; w++) begin : g_way_we
    assign way_we[w] = wr_accept && (wr_way_i == dcache_way_t'(w));
  end

  // --------------------------------------------------------------------------
  // Bank address select and data RAMs
  // --------------------------------------------------------------------------
  for (genvar b = 0; b < dcache_banks; b++) begin : g_bank
    logic rd0_here;
    logic rd1_here;

    assign rd0_here = rd_valid_i[0]
                      && (rd_addr_i[0].f.bank == dcache_bank_sel_width'(b));
    assign rd1_here = rd_valid_i[1]
                      && (rd_addr_i[1].f.bank == dcache_bank_sel_width'(b));

    // Read 0, then read 1, then the write
    assign bank_index[b] = rd0_here ? rd_addr_i[0].f.index :
                           rd1_here ? rd_addr_i[1].f.index :
                                      wr_addr_i.f.index;

    // Idle banks hold their last output
    assign bank_en[b] = (rd0_here && rd_accept_o[0])
                        || (rd1_here && rd_accept_o[1]) || wr_accept;

    for (genvar w = 0; w < dcache_ways; w++) begin : g_way
      // Bank 0 sits in the low word of the line
      single_port_ram #(
        .depth (dcache_sets),
        .width (dcache_word_width)
      ) i_data_ram (
        .clk    (clk),
        .en_i   (bank_en[b]),
        .addr_i (bank_index[b]),
        .we_i   (way_we[w]),
        .data_i (wr_line_i[b*dcache_word_width +: dcache_word_width]),
        .data_o (ram_q[w][b])
      );
    end
  end

  // Remember the bank, RAM data lands next cycle
  always_ff @(posedge clk) begin
    bank_q[0] <= rd_addr_i[0].f.bank;
    bank_q[1] <= rd_addr_i[1].f.bank;
  end

  // Route each bank output back to its port
  for (genvar p = 0; p < 2; p++) begin : g_port
    for (genvar w = 0; w < dcache_ways; w++) begin : g_way_out
      assign bank_data_o[p][w] = ram_q[w][bank_q[p]];
    end
  end

  // A line write reaches every bank at the write index, no load steals one
  a_wr_all_banks : assert property (@(posedge clk) disable iff (reset_i)
    (|way_we) |-> ((&bank_en)
                   && (bank_index == {dcache_banks{wr_addr_i.f.index}})));

endmodule : dcache_data_banks

// ==== dcache_tag/dcache_tag_array.sv ====
module dcache_tag_array (
  input  logic                                         clk,
  input  logic                                         reset_i,
  input  logic [1:0]                                   rd_accept_i,
  input  dcache_pkg::dcache_addr_u [1:0]               rd_addr_i,
  input  logic                                         wr_accept_i,
  input  dcache_pkg::dcache_addr_u                     wr_addr_i,
  input  dcache_pkg::dcache_way_t                      wr_way_i,
  output dcache_pkg::dcache_tag_t [1:0][dcache_pkg::dcache_ways-1:0] tag_o,
  output logic [1:0][dcache_pkg::dcache_ways-1:0]      valid_o
);

  import dcache_pkg::*;

  // Per copy address and enable
  dcache_index_t [1:0]    copy_index;
  logic [1:0]             copy_en;
  logic [dcache_ways-1:0] way_we;

  // Valid bits for every set
  logic [dcache_ways-1:0][dcache_sets-1:0] valid_q;
  logic [1:0][dcache_ways-1:0]             valid_rd_q;

  // --------------------------------------------------------------------------
  // Tag RAMs, one copy per read port
  // --------------------------------------------------------------------------
  for (genvar p = 0; p < 2; p++) begin : g_copy_addr
    // Write and reads never meet, so the write may steal the port
    assign copy_index[p] = wr_accept_i ? wr_addr_i.f.index : rd_addr_i[p].f.index;
    assign copy_en[p]    = wr_accept_i || rd_accept_i[p];
  end

  for (genvar w = 0; w < dcache_ways; w++) begin : g_way
    assign way_we[w] = wr_accept_i && (wr_way_i == dcache_way_t'(w));

    // Both copies take the same write
    for (genvar p = 0; p < 2; p++) begin : g_copy
      single_port_ram #(
        .depth (dcache_sets),
        .width (dcache_tag_width)
      ) i_tag_ram (
        .clk    (clk),
        .en_i   (copy_en[p]),
        .addr_i (copy_index[p]),
        .we_i   (way_we[w]),
        .data_i (wr_addr_i.f.tag),
        .data_o (tag_o[p][w])
      );
    end
  end

  // --------------------------------------------------------------------------
  // Valid register file
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (wr_accept_i) begin
      valid_q[wr_way_i][wr_addr_i.f.index] <= 1'b1;
    end
  end

  // Read alongside the tag RAMs, same one-cycle timing
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_rd_q <= '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (rd_accept_i[p]) begin
          for (int w = 0; w < dcache_ways; w++) begin
            valid_rd_q[p][w] <= valid_q[w][rd_addr_i[p].f.index];
          end
        end
      end
    end
  end

  assign valid_o = valid_rd_q;

endmodule : dcache_tag_array

// ==== rtl/dcache.sv ====
module dcache (
  input  logic                                          clk,
  input  logic                                          reset_i,
  // Read ports
  input  logic [1:0]                                    rd_valid_i,
  input  dcache_pkg::dcache_addr_u [1:0]                rd_addr_i,
  output logic [1:0]                                    rd_ready_o,
  output logic [1:0]                                    rsp_valid_o,
  output logic [1:0]                                    rsp_hit_o,
  output logic [1:0][dcache_pkg::dcache_word_width-1:0] rsp_data_o,
  // Line write port
  input  logic                                          wr_valid_i,
  input  dcache_pkg::dcache_addr_u                      wr_addr_i,
  input  dcache_pkg::dcache_way_t                       wr_way_i,
  input  dcache_pkg::dcache_line_t                      wr_line_i,
  output logic                                          wr_ready_o
);

  import dcache_pkg::*;

  logic [1:0] rd_accept;
  logic       wr_accept;

  // Lookup stage outputs
  dcache_tag_t [1:0][dcache_ways-1:0]                  tag;
  logic [1:0][dcache_ways-1:0]                         valid;
  logic [1:0][dcache_ways-1:0][dcache_word_width-1:0] bank_data;

  // Request delayed to line up with the RAM outputs
  logic [1:0]          accept_q;
  dcache_addr_u [1:0]  addr_q;

  assign wr_accept = wr_valid_i && wr_ready_o;

  // --------------------------------------------------------------------------
  // Data side, also owns the handshake
  // --------------------------------------------------------------------------
  dcache_data_banks i_data_banks (
    .clk         (clk),
    .reset_i     (reset_i),
    .rd_valid_i  (rd_valid_i),
    .rd_addr_i   (rd_addr_i),
    .wr_valid_i  (wr_valid_i),
    .wr_addr_i   (wr_addr_i),
    .wr_way_i    (wr_way_i),
    .wr_line_i   (wr_line_i),
    .rd_ready_o  (rd_ready_o),
    .wr_ready_o  (wr_ready_o),
    .rd_accept_o (rd_accept),
    .bank_data_o (bank_data)
  );

  // Tag side, looked up in parallel
  dcache_tag_array i_tag_array (
    .clk         (clk),
    .reset_i     (reset_i),
    .rd_accept_i (rd_accept),
    .rd_addr_i   (rd_addr_i),
    .wr_accept_i (wr_accept),
    .wr_addr_i   (wr_addr_i),
    .wr_way_i    (wr_way_i),
    .tag_o       (tag),
    .valid_o     (valid)
  );

  always_ff @(posedge clk) begin
    if (reset_i) begin
      accept_q <= '0;
      addr_q   <= '0;
    end else begin
      accept_q <= rd_accept;
      addr_q   <= rd_addr_i;
    end
  end

  // --------------------------------------------------------------------------
  // Hit select and response register
  // --------------------------------------------------------------------------
  dcache_hit_select i_hit_select (
    .clk         (clk),
    .reset_i     (reset_i),
    .accept_q_i  (accept_q),
    .addr_q_i    (addr_q),
    .tag_i       (tag),
    .valid_i     (valid),
    .bank_data_i (bank_data),
    .rsp_valid_o (rsp_valid_o),
    .rsp_hit_o   (rsp_hit_o),
    .rsp_data_o  (rsp_data_o)
  );

  // Every accepted read answers exactly two edges later
  for (genvar p = 0; p < 2; p++) begin : g_rsp_check
    a_rsp_latency : assert property (@(posedge clk) disable iff (reset_i)
      (rd_valid_i[p] && rd_ready_o[p]) |=> ##1 rsp_valid_o[p]);
  end

endmodule : dcache

// ==== rtl/dcache_hit_select.sv ====
module dcache_hit_select (
  input  logic                                                  clk,
  input  logic                                                  reset_i,
  input  logic [1:0]                                            accept_q_i,
  input  dcache_pkg::dcache_addr_u [1:0]                        addr_q_i,
  input  dcache_pkg::dcache_tag_t [1:0][dcache_pkg::dcache_ways-1:0] tag_i,
  input  logic [1:0][dcache_pkg::dcache_ways-1:0]               valid_i,
  input  logic [1:0][dcache_pkg::dcache_ways-1:0][dcache_pkg::dcache_word_width-1:0] bank_data_i,
  output logic [1:0]                                            rsp_valid_o,
  output logic [1:0]                                            rsp_hit_o,
  output logic [1:0][dcache_pkg::dcache_word_width-1:0]         rsp_data_o
);

  import dcache_pkg::*;

  logic [1:0][dcache_ways-1:0]       hit_way;
  logic [1:0]                        hit;
  logic [1:0][dcache_word_width-1:0] word;

  // Tag compare per port and way
  for (genvar p = 0; p < 2; p++) begin : g_port
    for (genvar w = 0; w < dcache_ways; w++) begin : g_way
      assign hit_way[p][w] = valid_i[p][w] && (tag_i[p][w] == addr_q_i[p].f.tag);
    end
    assign hit[p] = |hit_way[p];
  end

  // OR of the hitting way, zero on a miss
  always_comb begin
    word = '0;
    for (int p = 0; p < 2; p++) begin
      for (int w = 0; w < dcache_ways; w++) begin
        if (hit_way[p][w]) begin
          word[p] = word[p] | bank_data_i[p][w];
        end
      end
    end
  end

  // Response stage
  always_ff @(posedge clk) begin
    if (reset_i) begin
      rsp_valid_o <= '0;
      rsp_hit_o   <= '0;
    end else begin
      rsp_valid_o <= accept_q_i;
      rsp_hit_o   <= accept_q_i & hit;
    end
  end

  always_ff @(posedge clk) begin
    rsp_data_o <= word;
  end

  // Writer picks the way, same tag twice in one set would break this
  a_one_hit : assert property (@(posedge clk) disable iff (reset_i)
    (accept_q_i[0] |-> $onehot0(hit_way[0])) and (accept_q_i[1] |-> $onehot0(hit_way[1])));

endmodule : dcache_hit_select

// ==== rtl/single_port_ram.sv ====
module single_port_ram #(
  parameter int depth = 64,
  parameter int width = 32
) (
  input  logic                     clk,
  input  logic                     en_i,
  input  logic [$clog2(depth)-1:0] addr_i,
  input  logic                     we_i,
  input  logic [width-1:0]         data_i,
  output logic [width-1:0]         data_o
);

  // Storage array
  logic [width-1:0] mem [depth];

  // Write-first port
  // new data shows on the output in the write cycle
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= data_i;
        data_o      <= data_i;
      end else begin
        data_o      <= mem[addr_i];
      end
    end
  end

endmodule : single_port_ram

// ==== verif/dcache_tb.sv ====
module dcache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import dcache_pkg::*;

  // Cycle budget, reset + six tests with their drain cycles
  localparam int test_cycles = 5 + 50 + 100 + 20 + 20 + 25 + 1010;
  localparam int watchdog_ns = test_cycles * 20 + 2000;

  logic                              clk;
  logic                              reset_i;
  logic [1:0]                        rd_valid;
  dcache_addr_u [1:0]                rd_addr;
  logic [1:0]                        rd_ready;
  logic [1:0]                        rsp_valid;
  logic [1:0]                        rsp_hit;
  logic [1:0][dcache_word_width-1:0] rsp_data;
  logic                              wr_valid;
  dcache_addr_u                      wr_addr;
  dcache_way_t                       wr_way;
  dcache_line_t                      wr_line;
  logic                              wr_ready;

  // Reference model per set and way
  dcache_line_t model_line  [dcache_sets][dcache_ways];
  dcache_tag_t  model_tag   [dcache_sets][dcache_ways];
  logic         model_valid [dcache_sets][dcache_ways];

  // Expected results, accepted at the last edge and the one before
  logic [1:0]                        look_acc;
  logic [1:0]                        look_hit;
  logic [1:0][dcache_word_width-1:0] look_word;
  logic [1:0]                        resp_acc;
  logic [1:0]                        resp_hit;
  logic [1:0][dcache_word_width-1:0] resp_word;

  int hs_checks;
  int hs_errors;
  int cmp_checks;
  int cmp_errors;
  int start_checks;
  int start_errors;

  dcache i_dcache (
    .clk         (clk),
    .reset_i     (reset_i),
    .rd_valid_i  (rd_valid),
    .rd_addr_i   (rd_addr),
    .rd_ready_o  (rd_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_hit_o   (rsp_hit),
    .rsp_data_o  (rsp_data),
    .wr_valid_i  (wr_valid),
    .wr_addr_i   (wr_addr),
    .wr_way_i    (wr_way),
    .wr_line_i   (wr_line),
    .wr_ready_o  (wr_ready)
  );

  always #10 clk = ~clk;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic dcache_addr_u make_addr(input dcache_tag_t tag, input dcache_index_t index,
                                             input logic [1:0] bank);
    dcache_addr_u a;
    a.f.tag      = tag;
    a.f.index    = index;
    a.f.bank     = bank;
    a.f.byte_off = 2'($urandom);
    return a;
  endfunction

  // Hit in bit 32, word below; a miss reads as zero
  function automatic logic [32:0] ref_read(input dcache_addr_u a);
    logic [32:0] result;
    result = '0;
    for (int w = 0; w < dcache_ways; w++) begin
      if (model_valid[a.f.index][w] && model_tag[a.f.index][w] == a.f.tag) begin
        result = {1'b1, model_line[a.f.index][w][int'(a.f.bank) * dcache_word_width
                                                 +: dcache_word_width]};
      end
    end
    return result;
  endfunction

  // Reuse the way that already holds this tag, never two copies in one set
  function automatic dcache_way_t pick_way(input dcache_index_t index, input dcache_tag_t tag,
                                           input dcache_way_t way);
    dcache_way_t other;
    other = ~way;
    if (model_valid[index][other] && model_tag[index][other] == tag) begin
      return other;
    end
    return way;
  endfunction

  function automatic bit value_ok(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
    bit ok;
    ok = (got === exp);
    assert (ok) else $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    return ok;
  endfunction

  task automatic check_handshake(input string name, input logic got, input logic exp);
    hs_checks++;
    if (!value_ok(name, 32'(got), 32'(exp))) begin
      hs_errors++;
    end
  endtask

  // One clock; handshakes sampled at the rising edge, back at the falling edge
  task automatic step(output logic [1:0] rd_took, output logic wr_took);
    @(posedge clk);
    rd_took = rd_valid & rd_ready;
    wr_took = wr_valid & wr_ready;
    @(negedge clk);
  endtask

  // Hold each read until it is taken
  task automatic issue_reads(input logic [1:0] want, input dcache_addr_u a0,
                             input dcache_addr_u a1);
    logic [1:0] pending;
    logic [1:0] took;
    logic       wt;
    int         waited;
    pending    = want;
    rd_addr[0] = a0;
    rd_addr[1] = a1;
    waited     = 0;
    while (pending != 2'b00 && waited < 8) begin
      rd_valid = pending;
      step(took, wt);
      pending = pending & ~took;
      waited++;
    end
    rd_valid = 2'b00;
    hs_checks++;
    assert (pending == 2'b00) else begin
      $display("Read request on ports %b was not accepted within 8 cycles", pending);
      hs_errors++;
    end
  endtask

  task automatic write_line(input dcache_addr_u a, input dcache_way_t way,
                            input dcache_line_t line);
    logic [1:0] took;
    logic       wt;
    int         waited;
    wr_addr  = a;
    wr_way   = way;
    wr_line  = line;
    wr_valid = 1'b1;
    wt       = 1'b0;
    waited   = 0;
    while (!wt && waited < 8) begin
      step(took, wt);
      waited++;
    end
    wr_valid = 1'b0;
    hs_checks++;
    assert (wt) else begin
      $display("Line write was not accepted within 8 cycles");
      hs_errors++;
    end
  endtask

  task automatic begin_test();
    start_checks = hs_checks + cmp_checks;
    start_errors = hs_errors + cmp_errors;
  endtask

  // Idle long enough for the last responses to be compared
  task automatic end_test(input string name);
    logic [1:0] took;
    logic       wt;
    rd_valid = 2'b00;
    wr_valid = 1'b0;
    repeat (3) step(took, wt);
    $display("test %-14s checks %0d errors %0d", name,
             hs_checks + cmp_checks - start_checks, hs_errors + cmp_errors - start_errors);
  endtask

  // --------------------------------------------------------------------------
  // Expected results at the rising edge, compare at the falling edge
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    logic [32:0] expect_rd;
    if (reset_i) begin
      look_acc = 2'b00;
      resp_acc = 2'b00;
      for (int s = 0; s < dcache_sets; s++) begin
        for (int w = 0; w < dcache_ways; w++) begin
          model_valid[s][w] = 1'b0;
        end
      end
    end else begin
      resp_acc  = look_acc;
      resp_hit  = look_hit;
      resp_word = look_word;
      for (int p = 0; p < 2; p++) begin
        expect_rd    = ref_read(rd_addr[p]);
        look_acc[p]  = rd_valid[p] && rd_ready[p];
        look_hit[p]  = expect_rd[32];
        look_word[p] = expect_rd[31:0];
      end
      // Write lands after this edge's lookups
      if (wr_valid && wr_ready) begin
        model_line[wr_addr.f.index][wr_way]  = wr_line;
        model_tag[wr_addr.f.index][wr_way]   = wr_addr.f.tag;
        model_valid[wr_addr.f.index][wr_way] = 1'b1;
      end
    end
  end

  always @(negedge clk) begin
    for (int p = 0; p < 2; p++) begin
      cmp_checks++;
      if (!value_ok($sformatf("rsp_valid_o[%0d]", p), 32'(rsp_valid[p]), 32'(resp_acc[p]))) begin
        cmp_errors++;
      end
      if (resp_acc[p]) begin
        cmp_checks += 2;
        if (!value_ok($sformatf("rsp_hit_o[%0d]", p), 32'(rsp_hit[p]), 32'(resp_hit[p]))) begin
          cmp_errors++;
        end
        if (!value_ok($sformatf("rsp_data_o[%0d]", p), rsp_data[p], resp_word[p])) begin
          cmp_errors++;
        end
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the tests did not complete", watchdog_ns);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  initial begin
    dcache_index_t idx;
    dcache_tag_t   tag;
    dcache_way_t   way;
    logic [1:0]    took;
    logic          wt;
    logic [1:0]    pend;
    logic          wpend;
    void'($urandom(32'h3627));
    clk        = 1'b0;
    reset_i    = 1'b1;
    rd_valid   = 2'b00;
    rd_addr    = '0;
    wr_valid   = 1'b0;
    wr_addr    = '0;
    wr_way     = 1'b0;
    wr_line    = '0;
    hs_checks  = 0;
    hs_errors  = 0;
    cmp_checks = 0;
    cmp_errors = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    // Nothing valid yet, every read misses
    begin_test();
    repeat (20) issue_reads(2'b11, dcache_addr_u'($urandom), dcache_addr_u'($urandom));
    end_test("reset_miss");

    // Write, then read the whole line back right away
    begin_test();
    for (int i = 0; i < 16; i++) begin
      idx = dcache_index_t'($urandom);
      tag = dcache_tag_t'($urandom) & 22'h1fffff;
      way = pick_way(idx, tag, dcache_way_t'($urandom));
      write_line(make_addr(tag, idx, 2'd0), way, {$urandom, $urandom, $urandom, $urandom});
      issue_reads(2'b11, make_addr(tag, idx, 2'd0), make_addr(tag, idx, 2'd1));
      issue_reads(2'b11, make_addr(tag, idx, 2'd2), make_addr(tag, idx, 2'd3));
    end
    end_test("write_read");

    // Shared bank, same index then different index
    begin_test();
    tag = 22'h0abcde;
    write_line(make_addr(tag, 6'd5, 2'd0), pick_way(6'd5, tag, 1'b0),
               {$urandom, $urandom, $urandom, $urandom});
    write_line(make_addr(tag, 6'd6, 2'd0), pick_way(6'd6, tag, 1'b1),
               {$urandom, $urandom, $urandom, $urandom});
    rd_addr[0] = make_addr(tag, 6'd5, 2'd2);
    rd_addr[1] = make_addr(tag, 6'd5, 2'd2);
    rd_valid   = 2'b11;
    step(took, wt);
    check_handshake("rd_ready_o[1]", took[1], 1'b1);
    rd_addr[0] = make_addr(tag, 6'd5, 2'd1);
    rd_addr[1] = make_addr(tag, 6'd6, 2'd1);
    step(took, wt);
    check_handshake("rd_ready_o[0]", took[0], 1'b1);
    check_handshake("rd_ready_o[1]", took[1], 1'b0);
    rd_valid = 2'b10;
    step(took, wt);
    check_handshake("rd_ready_o[1]", took[1], 1'b1);
    end_test("bank_conflict");

    // Loads hold off the line write
    begin_test();
    tag = 22'h012345;
    idx = 6'd9;
    way = pick_way(idx, tag, 1'b1);
    write_line(make_addr(tag, idx, 2'd0), way, {4{32'h0badf00d}});
    wr_addr  = make_addr(tag, idx, 2'd0);
    wr_way   = way;
    wr_line  = {32'h600dcafe, 32'h600dbeef, 32'h600dd00d, 32'h600dface};
    wr_valid = 1'b1;
    for (int c = 0; c < 4; c++) begin
      rd_addr[0] = make_addr(tag, idx, 2'(c));
      rd_addr[1] = make_addr(tag, idx, 2'(c + 1));
      rd_valid   = 2'b11;
      step(took, wt);
      check_handshake("wr_ready_o", wt, 1'b0);
    end
    rd_valid = 2'b00;
    step(took, wt);
    check_handshake("wr_ready_o", wt, 1'b1);
    wr_valid = 1'b0;
    issue_reads(2'b11, make_addr(tag, idx, 2'd0), make_addr(tag, idx, 2'd1));
    issue_reads(2'b11, make_addr(tag, idx, 2'd2), make_addr(tag, idx, 2'd3));
    end_test("write_blocked");

    // Two tags side by side in one set, a third one misses
    begin_test();
    idx = 6'd40;
    write_line(make_addr(22'h2a5a5a, idx, 2'd0), 1'b0, {$urandom, $urandom, $urandom, $urandom});
    write_line(make_addr(22'h35a5a5, idx, 2'd0), 1'b1, {$urandom, $urandom, $urandom, $urandom});
    for (int b = 0; b < dcache_banks; b++) begin
      issue_reads(2'b11, make_addr(22'h2a5a5a, idx, 2'(b)), make_addr(22'h35a5a5, idx, 2'(b)));
    end
    issue_reads(2'b01, make_addr(22'h3c3c3c, idx, 2'd1), make_addr(22'h3c3c3c, idx, 2'd1));
    end_test("two_ways");

    // Random traffic on all ports, few tags and sets for many hits
    begin_test();
    pend  = 2'b00;
    wpend = 1'b0;
    for (int c = 0; c < 1000; c++) begin
      for (int p = 0; p < 2; p++) begin
        if (!pend[p] && ($urandom % 2 == 0)) begin
          rd_addr[p] = make_addr(dcache_tag_t'(32'h1000 + $urandom % 4),
                                 dcache_index_t'($urandom % 8), 2'($urandom));
          pend[p]    = 1'b1;
        end
      end
      if (!wpend && ($urandom % 4 == 0)) begin
        wr_addr = make_addr(dcache_tag_t'(32'h1000 + $urandom % 4),
                            dcache_index_t'($urandom % 8), 2'd0);
        wr_way  = pick_way(wr_addr.f.index, wr_addr.f.tag, dcache_way_t'($urandom));
        wr_line = {$urandom, $urandom, $urandom, $urandom};
        wpend   = 1'b1;
      end
      rd_valid = pend;
      wr_valid = wpend;
      step(took, wt);
      pend = pend & ~took;
      if (wt) begin
        wpend = 1'b0;
      end
    end
    end_test("random_mix");

    $display("total checks %0d errors %0d", hs_checks + cmp_checks, hs_errors + cmp_errors);
    if (hs_errors + cmp_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : dcache_tb
